// File: logic/dos_control.sv
// dos state flag and the z80 clock stall that lets the rom settle when dos comes on
module dos_control #(
	parameter int STALL_LEN = 3 // extra f0 cycles of stall after the turn-on cycle
) (
	input  logic fclk,
	input  logic rst,
	input  logic f0,
	input  logic dos_on,     // or of window entry strobes
	input  logic dos_off,    // or of window exit strobes
	output logic dos,
	output logic zclk_stall
);

	localparam int CW = (STALL_LEN > 1) ? $clog2(STALL_LEN + 1) : 1;

	logic [CW-1:0] stall_cnt; // remaining stall cycles, 0 = idle

	// turn-on wins over turn-off
	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (f0)
		begin
			if (dos_on)
				dos <= 1'b1;
			else if (dos_off)
				dos <= 1'b0;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			stall_cnt <= '0;
		else if (f0)
		begin
			if (dos_on)
				stall_cnt <= CW'(STALL_LEN);  // restart on every entry
			else if (stall_cnt != '0)
				stall_cnt <= stall_cnt - 1'b1;
		end
	end

	assign zclk_stall = dos_on || (stall_cnt != '0); // strobe covers first cycle

endmodule

// File: logic/page_select.sv
// picks the mapping of the addressed window and builds the xxBE readback byte
module page_select (
	input  logic                  fclk,
	input  logic                  rst,
	input  logic                  f0,
	input  pager_pkg::zbus_t      zbus,
	input  pager_pkg::win_map_t   maps [4],  // one per window
	input  pager_pkg::win_regs_t  regs [4],
	output pager_pkg::win_map_t   mem_map,   // page of the current access
	output pager_pkg::page_t      rd_data    // xxBE read byte
);

	pager_pkg::win_t      win;      // window of current address
	pager_pkg::win_regs_t sel_regs;
	pager_pkg::page_t     rd_nx;

	assign win      = zbus.addr[15:14];
	assign sel_regs = regs[win];

	// a9 low gives a page register, a9 high the flag nibble
	always_comb
	begin
		if (zbus.addr[9])
			rd_nx = {4'b0000, sel_regs.dos7ffd, sel_regs.ramnrom};
		else if (zbus.addr[8])
			rd_nx = sel_regs.page1;
		else
			rd_nx = sel_regs.page0;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			mem_map.page    <= pager_pkg::PAGE_FF; // service rom
			mem_map.romnram <= 1'b1;
			rd_data         <= pager_pkg::PAGE_FF;
		end
		else if (f0)
		begin
			mem_map <= maps[win];
			rd_data <= rd_nx;
		end
	end

endmodule

// File: logic/pager_pkg.sv
// shared widths, bus and mapping types for the z80 window pager, used by scoped name
package pager_pkg;

	typedef logic [7:0]  page_t;   // physical 16k page number
	typedef logic [1:0]  win_t;    // window number from addr 15:14
	typedef logic [15:0] zaddr_t;  // z80 address
	typedef logic [7:0]  zdata_t;  // z80 data byte
	typedef logic [5:0]  ppage_t;  // page field of 7ffd in pent1m mode

	localparam page_t PAGE_FF = 8'hFF; // service rom / nmi ram page
	localparam logic [5:0] DOS_ENTRY_HI = 6'h3D; // fetch from 3Dxx enters dos

	// z80 bus as seen by the pager
	typedef struct packed {
		zaddr_t addr;
		zdata_t data;
		logic   mreq_n;  // level, sampled at zneg
		logic   m1_n;    // level, sampled at zpos
	} zbus_t;

	// 7ffd paging state from the port decoder
	typedef struct packed {
		logic   rom;     // 7ffd d4, picks bank of each window
		ppage_t page;    // ram page bits
		logic   ram0_0;  // ram page 0 into window 0
		logic   on_1m;   // 1M addressing, else 128k
	} pent1m_t;

	// mapping result of one window
	typedef struct packed {
		page_t page;
		logic  romnram;  // 1 = rom
	} win_map_t;

	// register view of one window for the xxBE readback
	typedef struct packed {
		page_t      page0;
		page_t      page1;
		logic [1:0] dos7ffd;  // per bank, follow 7ffd/dos
		logic [1:0] ramnrom;  // per bank, 1 = ram
	} win_regs_t;

endpackage

// File: logic/pager_top.sv
// top of the z80 memory pager; connects bus decode, four windows, dos control and output stage
module pager_top #(
	parameter int STALL_LEN = 3 // dos entry stall, extra f0 cycles
) (
	input  logic                 fclk,
	input  logic                 rst,
	input  logic                 f0,
	input  logic                 zpos,
	input  logic                 zneg,
	input  pager_pkg::zbus_t     zbus,
	input  logic                 port_wr,
	input  logic                 pager_off,
	input  logic                 in_nmi,
	input  pager_pkg::pent1m_t   pent1m,     // 7ffd state
	output pager_pkg::win_map_t  mem_map,
	output pager_pkg::page_t     rd_data,
	output logic                 zclk_stall  // hold z80 clock
);

	logic                 fetch_stb;
	logic                 f7_wr;
	logic                 dos;
	logic [3:0]           dos_on_v;  // per window entry strobes
	logic [3:0]           dos_off_v;
	pager_pkg::win_map_t  maps [4];
	pager_pkg::win_regs_t regs [4];

	zbus_decode decode_i (
		.fclk      (fclk),
		.rst       (rst),
		.f0        (f0),
		.zpos      (zpos),
		.zneg      (zneg),
		.zbus      (zbus),
		.port_wr   (port_wr),
		.fetch_stb (fetch_stb),
		.f7_wr     (f7_wr)
	);

	// one pager per 16k window
	for (genvar w = 0; w < 4; w++)
	begin : win_g
		window_pager #(
			.WIN (pager_pkg::win_t'(w))
		) win_i (
			.fclk        (fclk),
			.rst         (rst),
			.f0          (f0),
			.zbus        (zbus),
			.fetch_stb   (fetch_stb),
			.zneg        (zneg),
			.f7_wr       (f7_wr),
			.pager_off   (pager_off),
			.in_nmi      (in_nmi),
			.pent1m      (pent1m),
			.dos         (dos),
			.map         (maps[w]),
			.regs        (regs[w]),
			.dos_on_stb  (dos_on_v[w]),
			.dos_off_stb (dos_off_v[w])
		);
	end

	dos_control #(
		.STALL_LEN (STALL_LEN)
	) dos_i (
		.fclk       (fclk),
		.rst        (rst),
		.f0         (f0),
		.dos_on     (|dos_on_v),   // only the fetched window can fire
		.dos_off    (|dos_off_v),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	page_select sel_i (
		.fclk    (fclk),
		.rst     (rst),
		.f0      (f0),
		.zbus    (zbus),
		.maps    (maps),
		.regs    (regs),
		.mem_map (mem_map),
		.rd_data (rd_data)
	);

endmodule

// File: logic/window_pager.sv
// one 16k window of the pager: page registers, page mapping and dos fetch detection
module window_pager #(
	parameter pager_pkg::win_t WIN = 2'd0 // window served, compared with addr 15:14
) (
	input  logic                  fclk,
	input  logic                  rst,
	input  logic                  f0,
	input  pager_pkg::zbus_t      zbus,
	input  logic                  fetch_stb,
	input  logic                  zneg,
	input  logic                  f7_wr,
	input  logic                  pager_off, // whole map is service rom
	input  logic                  in_nmi,
	input  pager_pkg::pent1m_t    pent1m,
	input  logic                  dos,
	output pager_pkg::win_map_t   map,
	output pager_pkg::win_regs_t  regs,
	output logic                  dos_on_stb,
	output logic                  dos_off_stb
);

	pager_pkg::page_t    pages [2]; // two banks, picked by 7ffd rom bit
	logic [1:0]          ramnrom;   // per bank, 1 = ram
	logic [1:0]          dos7ffd;   // per bank, page follows 7ffd or dos
	logic                bank;
	logic                in_win;
	logic                fetch_here;
	pager_pkg::page_t    bank_page;
	logic                bank_ram;
	logic                bank_7ffd;
	pager_pkg::win_map_t map_nx;

	assign bank      = pent1m.rom;
	assign in_win    = (zbus.addr[15:14] == WIN);
	assign bank_page = pages[bank];
	assign bank_ram  = ramnrom[bank];
	assign bank_7ffd = dos7ffd[bank];

	// page port writes land in the active bank
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			pages[0] <= pager_pkg::PAGE_FF;
			pages[1] <= pager_pkg::PAGE_FF;
			ramnrom  <= 2'b00;   // both banks rom
			dos7ffd  <= 2'b00;
		end
		else if (f0 && f7_wr && in_win)
		begin
			if (zbus.addr[11])
			begin
				// xFF7, 6 bit page plus flags
				pages[bank]   <= ~{2'b11, zbus.data[5:0]};
				ramnrom[bank] <= zbus.data[6];
				dos7ffd[bank] <= zbus.data[7];
			end
			else
			begin
				pages[bank]   <= ~zbus.data; // x7F7, full 4M ram page
				ramnrom[bank] <= 1'b1;
				// 7ffd flag kept so 7ffd paging works across all 4M
			end
		end
	end

	// page for this window, highest priority first
	always_comb
	begin
		map_nx.romnram = ~bank_ram;
		map_nx.page    = bank_page;
		if (pager_off)
		begin
			map_nx.romnram = 1'b1;
			map_nx.page    = pager_pkg::PAGE_FF;
		end
		else if ((WIN == 2'd0) && in_nmi)
		begin
			map_nx.romnram = 1'b0;   // nmi handler lives in last ram page
			map_nx.page    = pager_pkg::PAGE_FF;
		end
		else if ((WIN == 2'd0) && pent1m.ram0_0)
		begin
			map_nx.romnram = 1'b0;
			map_nx.page    = 8'h00;
		end
		else if (bank_7ffd)
		begin
			if (!bank_ram)
				map_nx.page = {bank_page[7:1], dos}; // dos picks basic or dos rom
			else if (pent1m.on_1m)
				map_nx.page = {bank_page[7:6], pent1m.page};
			else
				map_nx.page = {bank_page[7:3], pent1m.page[2:0]}; // 128k style
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			map.page    <= pager_pkg::PAGE_FF;
			map.romnram <= 1'b1;
		end
		else if (f0)
			map <= map_nx;
	end

	assign regs.page0   = pages[0];
	assign regs.page1   = pages[1];
	assign regs.dos7ffd = dos7ffd;
	assign regs.ramnrom = ramnrom;

	assign fetch_here = fetch_stb && zneg && in_win;

	// entry only through bank 1 as dos rom with 7ffd rom bit set
	assign dos_on_stb = fetch_here &&
	                    (zbus.addr[13:8] == pager_pkg::DOS_ENTRY_HI) &&
	                    dos7ffd[1] && !ramnrom[1] && pent1m.rom;

	assign dos_off_stb = fetch_here && bank_ram; // any fetch from ram leaves dos

endmodule

// File: logic/zbus_decode.sv
// samples z80 bus control on cpu edges and makes the fetch and xxF7 write strobes
module zbus_decode (
	input  logic              fclk,
	input  logic              rst,
	input  logic              f0,        // fclk enable
	input  logic              zpos,      // z80 clock rising edge strobe
	input  logic              zneg,      // z80 clock falling edge strobe
	input  pager_pkg::zbus_t  zbus,
	input  logic              port_wr,   // one cycle io write
	output logic              fetch_stb, // start of opcode fetch
	output logic              f7_wr      // write to an xxF7 page port
);

	logic m1_n_reg;   // m1 as of last zpos
	logic mreq_n_reg; // mreq as of last zneg

	// m1 goes low on the rising edge, latch it there
	always_ff @(posedge fclk)
	begin
		if (rst)
			m1_n_reg <= 1'b1;
		else if (f0 && zpos)
			m1_n_reg <= zbus.m1_n;
	end

	// previous mreq level for edge detection
	always_ff @(posedge fclk)
	begin
		if (rst)
			mreq_n_reg <= 1'b1;
		else if (f0 && zneg)
			mreq_n_reg <= zbus.mreq_n;
	end

	// mreq just fell inside an m1 cycle
	assign fetch_stb = f0 && zneg &&
	                   !m1_n_reg &&
	                   !zbus.mreq_n && mreq_n_reg;

	// xxF7 with a10 high covers x7F7 and xFF7
	assign f7_wr = port_wr &&
	               (zbus.addr[7:0] == 8'hF7) &&
	               zbus.addr[10];

endmodule

// File: tb.f
logic/pager_pkg.sv
logic/zbus_decode.sv
logic/window_pager.sv
logic/dos_control.sv
logic/page_select.sv
logic/pager_top.sv
tb/fclk_gen.sv
tb/pager_tb.sv

// File: tb/fclk_gen.sv
// testbench clock and reset source, 100 ns fclk with reset held for the first 10 cycles
module fclk_gen (
	output logic fclk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		fclk = 1'b0;
		forever
			#50 fclk = ~fclk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (10) @(posedge fclk);
		#10;
		rst = 1'b0;   // released just after the edge, like the other stimulus
	end

endmodule

// File: tb/pager_tb.sv
// testbench for the z80 pager; drives the bus in f0 cycles and checks results with assertions
module pager_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STALL_LEN = 3;

	logic                 fclk;
	logic                 rst;
	logic                 f0;
	logic                 zpos;
	logic                 zneg;
	pager_pkg::zbus_t     zbus;
	logic                 port_wr;
	logic                 pager_off;
	logic                 in_nmi;
	pager_pkg::pent1m_t   pent1m;
	pager_pkg::win_map_t  mem_map;
	pager_pkg::page_t     rd_data;
	logic                 zclk_stall;

	logic                 zphase;      // 0 = next f0 cycle is a zpos cycle
	integer               seed;
	int                   errors;
	int                   err_start;   // error count when the current test began
	int                   tests_run;
	int                   tests_ok;
	int                   stall_run;   // f0 cycles zclk_stall has been high in a row
	logic                 chk_map;     // check strobes lasting one fclk cycle each
	logic                 chk_rd;
	logic                 chk_lvl;
	pager_pkg::win_map_t  exp_map;
	pager_pkg::page_t     exp_rd;
	logic                 exp_dos;
	logic                 exp_stall;
	pager_pkg::page_t     ram_pg [4];  // bank 0 ram page written into each window

	fclk_gen clk_i (
		.fclk (fclk),
		.rst  (rst)
	);

	pager_top #(
		.STALL_LEN (STALL_LEN)
	) dut_i (
		.fclk       (fclk),
		.rst        (rst),
		.f0         (f0),
		.zpos       (zpos),
		.zneg       (zneg),
		.zbus       (zbus),
		.port_wr    (port_wr),
		.pager_off  (pager_off),
		.in_nmi     (in_nmi),
		.pent1m     (pent1m),
		.mem_map    (mem_map),
		.rd_data    (rd_data),
		.zclk_stall (zclk_stall)
	);

	// length of the current stall in f0 cycles
	always @(posedge fclk)
	begin
		if (rst)
			stall_run <= 0;
		else if (f0)
			stall_run <= zclk_stall ? stall_run + 1 : 0;
	end

	// checks fire only on cycles with f0 low so the outputs hold across the edge
	a_map: assert property (@(posedge fclk) disable iff (rst) chk_map |-> mem_map == exp_map)
	else
	begin
		errors++;
		$display("Fail mem_map got %h expected %h", mem_map, exp_map);
	end

	a_rd: assert property (@(posedge fclk) disable iff (rst) chk_rd |-> rd_data == exp_rd)
	else
	begin
		errors++;
		$display("Fail rd_data got %h expected %h", rd_data, exp_rd);
	end

	a_dos: assert property (@(posedge fclk) disable iff (rst) chk_lvl |-> dut_i.dos == exp_dos)
	else
	begin
		errors++;
		$display("Fail dos got %h expected %h", dut_i.dos, exp_dos);
	end

	a_stall: assert property (@(posedge fclk) disable iff (rst)
		chk_lvl |-> zclk_stall == exp_stall)
	else
	begin
		errors++;
		$display("Fail zclk_stall got %h expected %h", zclk_stall, exp_stall);
	end

	// a finished stall covered the turn-on cycle plus STALL_LEN
	a_stall_len: assert property (@(posedge fclk) disable iff (rst)
		(f0 && !zclk_stall && stall_run != 0) |-> stall_run == STALL_LEN + 1)
	else
	begin
		errors++;
		$display("Fail zclk_stall length got %h expected %h", stall_run, STALL_LEN + 1);
	end

	function automatic pager_pkg::win_map_t map_of(input pager_pkg::page_t pg, input logic rom);
		pager_pkg::win_map_t m;
		m.page    = pg;
		m.romnram = rom;
		return m;
	endfunction

	// xxBE read address in window w
	function automatic pager_pkg::zaddr_t rd_addr(input pager_pkg::win_t w, input logic a9,
		input logic a8);
		return {w, 4'b0000, a9, a8, 8'hBE};
	endfunction

	// one f0 cycle with zpos and zneg taking turns
	task automatic tick(input logic wr);
		@(posedge fclk);
		#10;
		f0      = 1'b1;
		zpos    = !zphase;
		zneg    = zphase;
		port_wr = wr;
		@(posedge fclk);
		#10;
		f0      = 1'b0;
		zpos    = 1'b0;
		zneg    = 1'b0;
		port_wr = 1'b0;
		zphase  = !zphase;
	endtask

	// x7F7 when xff is low, xFF7 when high
	task automatic port_write(input pager_pkg::win_t w, input logic xff,
		input pager_pkg::page_t d);
		zbus.addr = {w, 2'b00, xff ? 12'hFF7 : 12'h7F7};
		zbus.data = d;
		tick(1'b1);
	endtask

	task automatic check_map(input pager_pkg::zaddr_t a, input pager_pkg::win_map_t exp);
		int n;
		zbus.addr = a;
		n = 0;
		do
		begin
			tick(1'b0);
			n++;
		end
		while ((n < 2 || mem_map !== exp) && n < 8);   // two f0 cycles of latency
		exp_map = exp;
		chk_map = 1'b1;
		@(posedge fclk);
		#10;
		chk_map = 1'b0;
	endtask

	task automatic check_rd(input pager_pkg::zaddr_t a, input pager_pkg::page_t exp);
		int n;
		zbus.addr = a;
		n = 0;
		do
		begin
			tick(1'b0);
			n++;
		end
		while ((n < 2 || rd_data !== exp) && n < 8);
		exp_rd = exp;
		chk_rd = 1'b1;
		@(posedge fclk);
		#10;
		chk_rd = 1'b0;
	endtask

	task automatic check_lvl(input logic d, input logic s);
		exp_dos   = d;
		exp_stall = s;
		chk_lvl   = 1'b1;
		@(posedge fclk);
		#10;
		chk_lvl   = 1'b0;
	endtask

	// m1 low at zpos then mreq falls at the next zneg
	task automatic fetch_start(input pager_pkg::zaddr_t a);
		if (zphase)
			tick(1'b0);   // line up with a zpos cycle
		zbus.addr = a;
		zbus.m1_n = 1'b0;
		tick(1'b0);
		zbus.mreq_n = 1'b0;
		tick(1'b0);       // fetch strobe here
		zbus.m1_n   = 1'b1;
		zbus.mreq_n = 1'b1;
	endtask

	task automatic start_test();
		err_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_start)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
			$display("%s: %0d errors", name, errors - err_start);
	endtask

	initial
	begin
		int n;
		pager_pkg::page_t d;
		pager_pkg::page_t pg;
		pager_pkg::ppage_t p;
		logic [1:0] fl0;
		logic [1:0] fl1;
		f0          = 1'b0;
		zpos        = 1'b0;
		zneg        = 1'b0;
		zbus.addr   = '0;
		zbus.data   = '0;
		zbus.mreq_n = 1'b1;
		zbus.m1_n   = 1'b1;
		port_wr     = 1'b0;
		pager_off   = 1'b0;
		in_nmi      = 1'b0;
		pent1m      = '0;
		zphase      = 1'b0;
		chk_map     = 1'b0;
		chk_rd      = 1'b0;
		chk_lvl     = 1'b0;
		errors      = 0;
		tests_run   = 0;
		tests_ok    = 0;
		seed        = 32'h5dcc;
		n = 0;
		while (rst !== 1'b0 && n < 20)
		begin
			@(posedge fclk);
			n++;
		end
		if (rst !== 1'b0)
		begin
			$display("reset was never released");
			errors++;
		end
		#10;

		start_test();
		for (int w = 0; w < 4; w++)
		begin
			check_map({pager_pkg::win_t'(w), 14'h0000}, map_of(8'hFF, 1'b1));
			check_rd(rd_addr(pager_pkg::win_t'(w), 1'b0, 1'b0), 8'hFF);
			check_rd(rd_addr(pager_pkg::win_t'(w), 1'b0, 1'b1), 8'hFF);
		end
		check_lvl(1'b0, 1'b0);
		end_test("reset state");

		start_test();
		for (int w = 0; w < 4; w++)
		begin
			d = $random(seed);
			ram_pg[w] = ~d;
			port_write(pager_pkg::win_t'(w), 1'b0, d);
			check_map({pager_pkg::win_t'(w), 14'h1234}, map_of(~d, 1'b0));
			check_rd(rd_addr(pager_pkg::win_t'(w), 1'b0, 1'b0), ~d);
		end
		end_test("x7F7 write");

		start_test();
		d = $random(seed);
		d[7:6] = 2'b11;              // ram that follows 7ffd
		pg = {2'b00, ~d[5:0]};
		port_write(2'd2, 1'b1, d);
		p = $random(seed);
		pent1m.page = p;
		check_map(16'h8000, map_of({pg[7:3], p[2:0]}, 1'b0));
		pent1m.on_1m = 1'b1;
		check_map(16'h8000, map_of({pg[7:6], p}, 1'b0));
		pent1m.on_1m = 1'b0;
		d = $random(seed);
		pent1m.rom = 1'b1;           // bank 1 gets a plain ram page
		port_write(2'd2, 1'b0, d);
		check_map(16'h8000, map_of(~d, 1'b0));
		pent1m.rom = 1'b0;
		check_map(16'h8000, map_of({pg[7:3], p[2:0]}, 1'b0));
		end_test("xFF7 with 7ffd mapping");

		start_test();
		pager_off = 1'b1;
		for (int w = 0; w < 4; w++)
			check_map({pager_pkg::win_t'(w), 14'h0100}, map_of(8'hFF, 1'b1));
		pager_off = 1'b0;
		in_nmi = 1'b1;
		pent1m.ram0_0 = 1'b1;
		check_map(16'h0100, map_of(8'hFF, 1'b0));
		check_map(16'hC100, map_of(ram_pg[3], 1'b0));
		in_nmi = 1'b0;
		check_map(16'h0100, map_of(8'h00, 1'b0));
		check_map(16'h4100, map_of(ram_pg[1], 1'b0));
		pent1m.ram0_0 = 1'b0;
		check_map(16'h0100, map_of(ram_pg[0], 1'b0));
		end_test("overrides");

		start_test();
		pent1m.rom = 1'b1;
		d = $random(seed);
		d[7:6] = 2'b10;              // dos mapped rom in bank 1
		pg = {2'b00, ~d[5:0]};
		port_write(2'd0, 1'b1, d);
		check_map(16'h0000, map_of({pg[7:1], 1'b0}, 1'b1));
		fetch_start(16'h3D2A);
		check_lvl(1'b1, 1'b1);
		n = 0;
		while (zclk_stall && n < STALL_LEN)
		begin
			tick(1'b0);
			n++;
		end
		if (zclk_stall)
		begin
			$display("zclk_stall did not fall within STALL_LEN+1 f0 cycles of dos entry");
			errors++;
		end
		check_map(16'h0000, map_of({pg[7:1], 1'b1}, 1'b1));
		d = $random(seed);
		port_write(2'd1, 1'b0, d);   // window 1 bank 1 becomes ram
		fetch_start(16'h4000);
		check_lvl(1'b0, 1'b0);
		check_map(16'h0000, map_of({pg[7:1], 1'b0}, 1'b1));
		pent1m.rom = 1'b0;
		end_test("dos entry and exit");

		start_test();
		for (int k = 0; k < 2; k++)
		begin
			fl0 = k ? 2'b11 : 2'b10;   // d7 d6 for bank 0
			fl1 = k ? 2'b00 : 2'b01;
			d = $random(seed);
			pent1m.rom = 1'b0;
			port_write(2'd3, 1'b1, {fl0, d[5:0]});
			d = $random(seed);
			pent1m.rom = 1'b1;
			port_write(2'd3, 1'b1, {fl1, d[5:0]});
			check_rd(rd_addr(2'd3, 1'b1, 1'b0), {4'b0000, fl1[1], fl0[1], fl1[0], fl0[0]});
		end
		pent1m.rom = 1'b0;
		end_test("flag readback");

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
